// File: src/rob_pkg.sv
package rob_pkg;

  // queue geometry
  localparam int rob_depth = 16;
  localparam int tag_w = 4;
  localparam int num_regs = 32;

  // operations the ALU may hold at once
  localparam int alu_credits = 2;
  localparam int alu_cnt_w = $clog2(alu_credits + 1);

  typedef logic [tag_w-1:0] rob_tag_t;
  typedef logic [tag_w:0] rob_cnt_t;
  typedef logic [alu_cnt_w-1:0] alu_cnt_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [1:0] entry_state_t;

  // major opcodes kept in this core
  localparam logic [6:0] op_imm_opc = 7'd19;
  localparam logic [6:0] op_reg_opc = 7'd51;

  // ALU operation codes
  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_and = 4'd2;
  localparam alu_op_t alu_or = 4'd3;
  localparam alu_op_t alu_xor = 4'd4;
  localparam alu_op_t alu_sll = 4'd5;
  localparam alu_op_t alu_srl = 4'd6;
  localparam alu_op_t alu_sra = 4'd7;
  localparam alu_op_t alu_slt = 4'd8;
  localparam alu_op_t alu_sltu = 4'd9;

  // life of a queue entry
  localparam entry_state_t st_wait = 2'd0;
  localparam entry_state_t st_issued = 2'd1;
  localparam entry_state_t st_done = 2'd2;

endpackage

// File: src/rename_regfile.sv
`timescale 1ns/1ps

module rename_regfile import rob_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1_addr,
  output word_t     rs1_value,
  output logic      rs1_busy,
  output rob_tag_t  rs1_tag,
  input  reg_addr_t rs2_addr,
  output word_t     rs2_value,
  output logic      rs2_busy,
  output rob_tag_t  rs2_tag,
  input  logic      rename_en,
  input  reg_addr_t rename_rd,
  input  rob_tag_t  rename_tag,
  input  logic      commit_en,
  input  reg_addr_t commit_rd,
  input  rob_tag_t  commit_tag,
  input  word_t     commit_value
);

  word_t    rf_value [num_regs];
  logic     rf_busy [num_regs];
  rob_tag_t rf_tag [num_regs];

  // x0 is never written, so it stays zero and idle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        rf_value[i] <= '0;
        rf_busy[i] <= 1'b0;
      end
    end else begin
      if (commit_en && commit_rd != '0) begin
        rf_value[commit_rd] <= commit_value;
        // only the newest producer releases the register
        if (rf_tag[commit_rd] == commit_tag) begin
          rf_busy[commit_rd] <= 1'b0;
        end
      end
      // a same-cycle rename wins over the release
      if (rename_en && rename_rd != '0) begin
        rf_busy[rename_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rename_en && rename_rd != '0) begin
      rf_tag[rename_rd] <= rename_tag;
    end
  end

  assign rs1_value = rf_value[rs1_addr];
  assign rs1_busy = rf_busy[rs1_addr];
  assign rs1_tag = rf_tag[rs1_addr];
  assign rs2_value = rf_value[rs2_addr];
  assign rs2_busy = rf_busy[rs2_addr];
  assign rs2_tag = rf_tag[rs2_addr];

endmodule

// File: src/rob_entry_table.sv
`timescale 1ns/1ps

module rob_entry_table import rob_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      instr_valid,
  input  word_t     instr,
  input  word_t     instr_pc,
  input  logic      cdb_valid,
  input  rob_tag_t  cdb_tag,
  input  word_t     cdb_value,
  input  logic      issue_mark,
  input  rob_tag_t  issue_mark_tag,
  output rob_tag_t  head,
  output rob_tag_t  tail,
  output word_t     entry_instr [rob_depth],
  output logic      entry_done [rob_depth],
  output word_t     entry_value [rob_depth],
  output logic      commit_en,
  output reg_addr_t commit_rd,
  output rob_tag_t  commit_tag,
  output word_t     commit_value,
  output logic      fetch_credit,
  output logic      commit_valid
);

  logic         entry_busy [rob_depth];
  entry_state_t entry_state [rob_depth];
  reg_addr_t    entry_rd [rob_depth];
  logic         head_ready;

  assign head_ready = entry_busy[head] && (entry_state[head] == st_done);

  always_comb begin
    for (int i = 0; i < rob_depth; i++) begin
      entry_done[i] = (entry_state[i] == st_done);
    end
  end

  // pointers, occupancy and entry state
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      commit_valid <= 1'b0;
      for (int i = 0; i < rob_depth; i++) begin
        entry_busy[i] <= 1'b0;
        entry_state[i] <= st_wait;
      end
    end else begin
      commit_valid <= head_ready;
      // retire the oldest entry once its result is in
      if (head_ready) begin
        entry_busy[head] <= 1'b0;
        head <= head + 1'b1;
      end
      // fetch only sends while holding a credit, so tail is always free
      if (instr_valid) begin
        entry_busy[tail] <= 1'b1;
        entry_state[tail] <= st_wait;
        tail <= tail + 1'b1;
      end
      if (issue_mark) begin
        entry_state[issue_mark_tag] <= st_issued;
      end
      if (cdb_valid) begin
        entry_state[cdb_tag] <= st_done;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      entry_instr[tail] <= instr;
      entry_rd[tail] <= instr[11:7];
    end
    if (cdb_valid) begin
      entry_value[cdb_tag] <= cdb_value;
    end
    // freed slot keeps done and value, so forwarding still works
    // until the register file has taken the commit
    if (head_ready) begin
      commit_rd <= entry_rd[head];
      commit_tag <= head;
      commit_value <= entry_value[head];
    end
  end

  // one credit back to fetch per retired entry
  assign fetch_credit = commit_valid;
  assign commit_en = commit_valid;

endmodule

// File: src/rob_issue.sv
`timescale 1ns/1ps

module rob_issue import rob_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  rob_tag_t  head,
  input  rob_tag_t  tail,
  input  word_t     entry_instr [rob_depth],
  input  logic      entry_done [rob_depth],
  input  word_t     entry_value [rob_depth],
  output reg_addr_t rs1_addr,
  input  word_t     rs1_value,
  input  logic      rs1_busy,
  input  rob_tag_t  rs1_tag,
  output reg_addr_t rs2_addr,
  input  word_t     rs2_value,
  input  logic      rs2_busy,
  input  rob_tag_t  rs2_tag,
  output logic      rename_en,
  output reg_addr_t rename_rd,
  output rob_tag_t  rename_tag,
  output logic      issue_mark,
  output rob_tag_t  issue_mark_tag,
  input  logic      cdb_valid,
  output logic      issue_valid,
  output alu_op_t   issue_op,
  output word_t     issue_vj,
  output word_t     issue_vk,
  output rob_tag_t  issue_tag
);

  rob_tag_t issue_ptr;
  rob_tag_t tail_q;
  rob_tag_t head_q;
  rob_cnt_t occ_q;
  rob_cnt_t iss_q;
  rob_cnt_t occupancy;
  rob_cnt_t in_flight;
  alu_cnt_t alu_cnt;
  word_t    cur;
  word_t    imm;
  word_t    src1;
  word_t    src2;
  logic     enq_seen;
  logic     deq_seen;
  logic     entry_ready;
  logic     use_rs2;
  logic     src1_ok;
  logic     src2_ok;
  logic     fire;

  function automatic alu_op_t decode_op(input word_t ins);
    logic [2:0] f3;
    logic       alt;
    logic       is_reg;
    alu_op_t    op;
    f3 = ins[14:12];
    alt = ins[30];
    is_reg = (ins[6:0] == op_reg_opc);
    case (f3)
      3'b000: op = (is_reg && alt) ? alu_sub : alu_add;
      3'b001: op = alu_sll;
      3'b010: op = alu_slt;
      3'b011: op = alu_sltu;
      3'b100: op = alu_xor;
      3'b101: op = alt ? alu_sra : alu_srl;
      3'b110: op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  // table occupancy seen through pointer movement
  assign enq_seen = (tail != tail_q);
  assign deq_seen = (head != head_q);
  assign occupancy = occ_q + rob_cnt_t'(enq_seen) - rob_cnt_t'(deq_seen);
  assign in_flight = iss_q - rob_cnt_t'(deq_seen);
  assign entry_ready = (occupancy != in_flight);

  assign cur = entry_instr[issue_ptr];
  assign rs1_addr = cur[19:15];
  assign rs2_addr = cur[24:20];
  assign use_rs2 = (cur[6:0] == op_reg_opc);

  // busy source can still be taken from a finished entry
  assign src1_ok = !rs1_busy || entry_done[rs1_tag];
  assign src2_ok = !use_rs2 || !rs2_busy || entry_done[rs2_tag];
  assign src1 = rs1_busy ? entry_value[rs1_tag] : rs1_value;
  assign src2 = rs2_busy ? entry_value[rs2_tag] : rs2_value;

  // shift immediates carry only shamt
  always_comb begin
    if ((cur[6:0] == op_imm_opc) && (cur[14:12] == 3'b001 || cur[14:12] == 3'b101)) begin
      imm = {27'b0, cur[24:20]};
    end else begin
      imm = {{20{cur[31]}}, cur[31:20]};
    end
  end

  assign fire = entry_ready && (alu_cnt < alu_credits) && src1_ok && src2_ok;

  assign issue_mark = fire;
  assign issue_mark_tag = issue_ptr;
  assign rename_en = fire;
  assign rename_rd = cur[11:7];
  assign rename_tag = issue_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 1'b0;
      issue_ptr <= '0;
      tail_q <= '0;
      head_q <= '0;
      occ_q <= '0;
      iss_q <= '0;
      alu_cnt <= '0;
    end else begin
      issue_valid <= fire;
      tail_q <= tail;
      head_q <= head;
      occ_q <= occupancy;
      iss_q <= in_flight + rob_cnt_t'(fire);
      if (fire) begin
        issue_ptr <= issue_ptr + 1'b1;
      end
      // each CDB result hands one ALU credit back
      alu_cnt <= alu_cnt + alu_cnt_t'(fire) - alu_cnt_t'(cdb_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      issue_op <= decode_op(cur);
      issue_vj <= src1;
      issue_vk <= use_rs2 ? src2 : imm;
      issue_tag <= issue_ptr;
    end
  end

endmodule

// File: src/rob_top.sv
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      instr_valid,
  input  word_t     instr,
  input  word_t     instr_pc,
  output logic      fetch_credit,
  output logic      issue_valid,
  output alu_op_t   issue_op,
  output word_t     issue_vj,
  output word_t     issue_vk,
  output rob_tag_t  issue_tag,
  input  logic      cdb_valid,
  input  rob_tag_t  cdb_tag,
  input  word_t     cdb_value,
  output logic      commit_valid,
  output reg_addr_t commit_rd,
  output word_t     commit_value
);

  // table to issue
  rob_tag_t  head;
  rob_tag_t  tail;
  word_t     entry_instr [rob_depth];
  logic      entry_done [rob_depth];
  word_t     entry_value [rob_depth];
  logic      issue_mark;
  rob_tag_t  issue_mark_tag;

  // register file ports
  reg_addr_t rs1_addr;
  word_t     rs1_value;
  logic      rs1_busy;
  rob_tag_t  rs1_tag;
  reg_addr_t rs2_addr;
  word_t     rs2_value;
  logic      rs2_busy;
  rob_tag_t  rs2_tag;
  logic      rename_en;
  reg_addr_t rename_rd;
  rob_tag_t  rename_tag;
  logic      commit_en;
  rob_tag_t  commit_tag;

  rob_entry_table u_table (.*);

  rob_issue u_issue (.*);

  rename_regfile u_regfile (.*);

endmodule

// File: tb/rob_checker.sv
`timescale 1ns/1ps

module rob_checker import rob_pkg::*; (
  input logic clk,
  input logic rst,
  input logic instr_valid,
  input logic issue_valid,
  input logic cdb_valid,
  input logic commit_valid,
  input logic fetch_credit
);

  // operations seen leaving on issue but not yet back on the CDB
  int alu_open;
  // entries taken from fetch and not yet handed back as credits
  int rob_used;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_open <= 0;
      rob_used <= 0;
    end else begin
      alu_open <= alu_open + int'(issue_valid) - int'(cdb_valid);
      rob_used <= rob_used + int'(instr_valid) - int'(fetch_credit);
    end
  end

  a_alu_limit: assert property (@(posedge clk) disable iff (rst) alu_open <= alu_credits)
    else $error("more than %0d ALU operations outstanding", alu_credits);

  // outputs come out of a reset edge low
  a_reset_quiet: assert property (@(posedge clk) rst |=> !(commit_valid || issue_valid))
    else $error("commit_valid or issue_valid high out of reset");

  // a credit only comes back with a commit of an entry that was taken
  a_credit_commit: assert property (@(posedge clk) disable iff (rst)
    fetch_credit |-> (commit_valid && rob_used > 0))
    else $error("fetch_credit pulsed without a committed entry");

endmodule

bind rob_top rob_checker u_checker (.*);

// File: tb/tb_rob.sv
`timescale 1ns/1ps

module tb_rob import rob_pkg::*; ();

  localparam int n_cases = 22;
  localparam int timeout_cycles = 2000;

  logic      clk;
  logic      rst;
  logic      instr_valid = 1'b0;
  word_t     instr = '0;
  word_t     instr_pc = '0;
  logic      fetch_credit;
  logic      issue_valid;
  alu_op_t   issue_op;
  word_t     issue_vj;
  word_t     issue_vk;
  rob_tag_t  issue_tag;
  logic      cdb_valid = 1'b0;
  rob_tag_t  cdb_tag = '0;
  word_t     cdb_value = '0;
  logic      commit_valid;
  reg_addr_t commit_rd;
  word_t     commit_value;

  // three words per case: instruction, rd, committed value
  word_t       case_mem [3*n_cases];
  logic        started;
  int          credits;
  int          fetched;
  int          committed;
  int          n_tests;
  int          n_fail;
  int          cycle;
  logic [31:0] lcg_state;

  // results waiting inside the ALU model
  rob_tag_t alu_tag_q [$];
  word_t    alu_val_q [$];
  int       alu_due_q [$];

  rob_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // RISC-V integer semantics
  function automatic word_t alu_result(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or: return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return $signed(a) >>> b[4:0];
      alu_slt: return word_t'($signed(a) < $signed(b));
      alu_sltu: return word_t'(a < b);
      default: return '0;
    endcase
  endfunction

  task automatic report_test(input string name, input logic ok);
    n_tests++;
    if (ok) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED", name);
    end
  endtask

  // fetch side, spends one credit per instruction sent
  always @(posedge clk) begin
    logic send;
    if (rst || !started) begin
      instr_valid <= 1'b0;
      credits <= rob_depth;
      fetched <= 0;
    end else begin
      send = (fetched < n_cases) && (credits > 0);
      instr_valid <= send;
      if (send) begin
        instr <= case_mem[3*fetched];
        instr_pc <= word_t'(4 * fetched);
      end
      fetched <= fetched + int'(send);
      credits <= credits - int'(send) + int'(fetch_credit);
    end
  end

  // ALU model, each result comes back 0 to 5 cycles later
  always @(posedge clk) begin
    int pick;
    if (rst) begin
      cdb_valid <= 1'b0;
      cycle = 0;
      lcg_state = 32'h3fe3;
      alu_tag_q.delete();
      alu_val_q.delete();
      alu_due_q.delete();
    end else begin
      cycle++;
      if (issue_valid) begin
        lcg_state = lcg_next(lcg_state);
        alu_tag_q.push_back(issue_tag);
        alu_val_q.push_back(alu_result(issue_op, issue_vj, issue_vk));
        alu_due_q.push_back(cycle + int'((lcg_state >> 16) % 32'd6));
      end
      // first due result in the queue, not necessarily the oldest
      pick = -1;
      for (int i = 0; i < alu_due_q.size(); i++) begin
        if (pick < 0 && alu_due_q[i] <= cycle) begin
          pick = i;
        end
      end
      cdb_valid <= (pick >= 0);
      if (pick >= 0) begin
        cdb_tag <= alu_tag_q[pick];
        cdb_value <= alu_val_q[pick];
        alu_tag_q.delete(pick);
        alu_val_q.delete(pick);
        alu_due_q.delete(pick);
      end
    end
  end

  initial begin
    int        waited;
    int        fails_before;
    logic      flight_ok;
    logic      ok;
    reg_addr_t exp_rd;
    word_t     exp_val;
    rst <= 1'b1;
    started = 1'b0;
    n_tests = 0;
    n_fail = 0;
    committed = 0;
    flight_ok = 1'b1;
    $readmemh("tb/rob_cases.txt", case_mem);
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // no fetch yet, so nothing may move
    fails_before = n_fail;
    repeat (5) begin
      @(negedge clk);
      assert (!commit_valid && !issue_valid && !fetch_credit)
        else begin
          $display("** Error at %0t: DUT output active while idle after reset", $time);
          n_fail++;
        end
    end
    report_test("idle after reset", n_fail == fails_before);

    @(posedge clk);
    started <= 1'b1;
    waited = 0;
    while (committed < n_cases && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
      assert (fetched - committed <= rob_depth)
        else begin
          $display("** Error at %0t: %0d instructions in flight", $time, fetched - committed);
          n_fail++;
          flight_ok = 1'b0;
        end
      if (commit_valid) begin
        exp_rd = reg_addr_t'(case_mem[3*committed+1]);
        exp_val = case_mem[3*committed+2];
        ok = (commit_rd == exp_rd) && (commit_value == exp_val);
        assert (ok)
          else begin
            $display("** Error at %0t: commit %0d wrote x%0d=%h, expected x%0d=%h", $time,
                     committed, commit_rd, commit_value, exp_rd, exp_val);
            n_fail++;
          end
        report_test($sformatf("commit %0d", committed), ok);
        committed++;
      end
    end
    report_test("in-flight bound", flight_ok);

    assert (committed == n_cases)
      else begin
        $display("timeout: only %0d of %0d instructions committed", committed, n_cases);
        n_fail++;
      end
    report_test("all committed", committed == n_cases);

    $display("%0d tests run, %0d failures", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb/rob_cases.txt
// columns: instruction word, expected rd, expected committed value
// registers start at zero, values follow RV32I semantics
00500093 01 00000005
00708113 02 0000000c
002081b3 03 00000011
40118233 04 0000000c
00311293 05 00000060
fff2c313 06 ffffff9f
40235393 07 ffffffe7
01c35413 08 0000000f
0013a4b3 09 00000001
0013b533 0a 00000000
003375b3 0b 00000011
00546633 0c 0000006f
fff08093 01 00000004
001086b3 0d 00000008
00109733 0e 00000040
401357b3 0f fffffff9
00135833 10 0ffffff9
03c67893 11 0000002c
7008e913 12 0000072c
00d949b3 13 00000724
fff3ba13 14 00000001
fe23aa93 15 00000000

// File: filelist.f
src/rob_pkg.sv
src/rename_regfile.sv
src/rob_entry_table.sv
src/rob_issue.sv
src/rob_top.sv
tb/rob_checker.sv
tb/tb_rob.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ROB testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rob -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_rob)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1
